//--- Bender.yml
package:
  name: prci

sources:
  - hw/prci_pkg.sv
  - hw/prci_evq_if.sv
  - hw/prci_reset_seq.sv
  - hw/prci_event_fifo.sv
  - hw/prci_apb_regs.sv
  - hw/prci_top.sv
  - target: test
    files:
      - bench/prci_chk.sv
      - bench/prci_tb.sv

//--- bench/prci_chk.sv
`timescale 1ns/100ps

module prci_chk (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_psel,
  input logic i_penable,
  input logic i_pready,
  input logic i_sys_nrst,
  input logic i_dbg_nrst,
  input logic i_sys_locked,
  input logic i_ddr_locked
);

  // Zero-wait-state slave
  a_pready: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_psel && i_penable) |-> i_pready)
    else begin
      $error("pready low in an APB access phase");
      prci_tb.errors++;
    end

  // System domain never leaves reset before debug
  a_nrst_order: assert property (@(posedge i_clk) i_sys_nrst |-> i_dbg_nrst)
    else begin
      $error("system reset released while debug reset is asserted");
      prci_tb.errors++;
    end

  // Sync delay plus one registered stage
  a_lock_loss: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ($fell(i_sys_locked) || $fell(i_ddr_locked)) |-> ##[0:3] !i_sys_nrst)
    else begin
      $error("system reset not asserted within 3 cycles of lock loss");
      prci_tb.errors++;
    end

endmodule

//--- bench/prci_tb.sv
`timescale 1ns/100ps

module prci_tb;

  import prci_pkg::*;

  localparam int RST_HOLD   = 16;
  localparam int EV_DEPTH   = 8;
  // Generous bound over the summed length of all tests
  localparam int MAX_CYCLES = 4000;

  logic        clk;
  logic        arst_n;
  logic        dmireset;
  logic        sys_locked;
  logic        ddr_locked;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sys_nrst;
  logic        dbg_nrst;

  logic [15:0]             lfsr;
  logic [PRCI_STAMP_W-1:0] stamp_model;
  prci_event_t             exp_q[$];
  logic [31:0]             exp_rst_cnt;
  int                      cycles = 0;
  int                      errors;
  int                      tests;
  int                      failed_tests;
  int                      errors_at_start;
  string                   cur_test;

  prci_top #(
    .RST_HOLD(RST_HOLD),
    .EV_DEPTH(EV_DEPTH)
  ) prci_top_inst (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_dmireset  (dmireset),
    .i_sys_locked(sys_locked),
    .i_ddr_locked(ddr_locked),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata),
    .o_pready    (pready),
    .o_pslverr   (pslverr),
    .o_sys_nrst  (sys_nrst),
    .o_dbg_nrst  (dbg_nrst)
  );

  bind prci_top prci_chk chk_inst (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pready    (o_pready),
    .i_sys_nrst  (o_sys_nrst),
    .i_dbg_nrst  (o_dbg_nrst),
    .i_sys_locked(i_sys_locked),
    .i_ddr_locked(i_ddr_locked)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Free-running cycle count, the reference for event stamps
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stamp_model <= '0;
    end else begin
      stamp_model <= stamp_model + 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [31:0] status_bits(input logic sys, ddr, nrst, avail, ovf);
    logic [31:0] w;
    w              = '0;
    w[ST_SYS_LOCK] = sys;
    w[ST_DDR_LOCK] = ddr;
    w[ST_SYS_NRST] = nrst;
    w[ST_EV_AVAIL] = avail;
    w[ST_OVERFLOW] = ovf;
    return w;
  endfunction

  task automatic cmp_bit(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", cur_test, expected, actual);
      errors++;
    end
  endtask

  task automatic cmp_word(input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", cur_test, expected, actual);
      errors++;
    end
  endtask

  task automatic cmp_event(input prci_event_t expected, input prci_event_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected code %0d stamp 0x%04h, actual code %0d stamp 0x%04h",
               cur_test, expected.code, expected.stamp, actual.code, actual.stamp);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      $display("%s: ok", cur_test);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  // Setup and access phase, zero wait states
  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    cmp_bit(1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    cmp_bit(1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic read_word(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    cmp_bit(1'b0, err);
    cmp_word(expected, data);
  endtask

  task automatic read_event();
    logic [31:0] data;
    logic        err;
    prci_event_t actual;
    prci_event_t expected;
    apb_read(REG_EVENT, data, err);
    actual.code  = prci_ev_code_e'(data[EVR_CODE_LO +: 3]);
    actual.stamp = data[PRCI_STAMP_W-1:0];
    if (exp_q.size() == 0) begin
      $display("%s: more events were read than were logged", cur_test);
      errors++;
    end else begin
      expected = exp_q.pop_front();
      cmp_bit(1'b1, data[EVR_VALID]);
      cmp_event(expected, actual);
    end
  endtask

  task automatic drive_lock(input logic is_ddr, input logic level);
    prci_event_t ev;
    @(posedge clk);
    if (is_ddr) begin
      ddr_locked <= level;
    end else begin
      sys_locked <= level;
    end
    @(negedge clk);
    if (is_ddr) begin
      ev.code = level ? EV_DDR_LOCK : EV_DDR_UNLOCK;
    end else begin
      ev.code = level ? EV_SYS_LOCK : EV_SYS_UNLOCK;
    end
    // Two synchronizer stages, then the event is registered
    ev.stamp = stamp_model + 2'd2;
    exp_q.push_back(ev);
  endtask

  task automatic request_sw_reset();
    prci_event_t ev;
    logic        err;
    apb_write(REG_CONTROL, 32'd1 << CT_SW_RESET, err);
    cmp_bit(1'b0, err);
    @(negedge clk);
    ev.code  = EV_SW_RESET;
    ev.stamp = stamp_model;
    exp_q.push_back(ev);
  endtask

  task automatic pulse_dmi();
    prci_event_t ev;
    @(posedge clk);
    dmireset <= 1'b1;
    @(negedge clk);
    // Pulse is not synchronized, logged on the next edge
    ev.code  = EV_DMI_RESET;
    ev.stamp = stamp_model;
    exp_q.push_back(ev);
    @(posedge clk);
    dmireset <= 1'b0;
  endtask

  task automatic wait_sys_nrst(input logic level);
    int guard;
    guard = 0;
    @(negedge clk);
    while (sys_nrst !== level && guard < 100) begin
      @(negedge clk);
      guard++;
    end
    if (sys_nrst !== level) begin
      $display("%s: system reset never reached level %b", cur_test, level);
      errors++;
    end
  endtask

  // Edges from the lock change until the system reset is seen released
  task automatic check_release_delay();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end while (sys_nrst !== 1'b1 && n < 100);
    cmp_word(RST_HOLD + 3, n);
  endtask

  task automatic check_low_pulse();
    int guard;
    int width;
    guard = 0;
    width = 0;
    @(negedge clk);
    while (sys_nrst === 1'b1 && guard < 50) begin
      @(negedge clk);
      guard++;
    end
    while (sys_nrst === 1'b0 && width < 1000) begin
      width++;
      @(negedge clk);
    end
    cmp_word(RST_HOLD + 1, width);
  endtask

  task automatic bring_up();
    int gap;
    start_test("bring_up");
    repeat (2) @(negedge clk);
    cmp_bit(1'b0, dbg_nrst);
    cmp_bit(1'b0, sys_nrst);
    cmp_bit(1'b0, pslverr);
    repeat (2) @(negedge clk);
    cmp_bit(1'b1, dbg_nrst);
    take_bits(4, gap);
    repeat (gap) @(posedge clk);
    drive_lock(1'b0, 1'b1);
    take_bits(4, gap);
    repeat (gap + 1) @(posedge clk);
    drive_lock(1'b1, 1'b1);
    check_release_delay();
    read_event();
    read_event();
    read_word(REG_EVENT, 32'h0);
    read_word(REG_STATUS, status_bits(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
    read_word(REG_RSTCNT, exp_rst_cnt);
    end_test();
  endtask

  task automatic lock_loss();
    int gap;
    start_test("lock_loss");
    drive_lock(1'b1, 1'b0);
    wait_sys_nrst(1'b0);
    cmp_bit(1'b1, dbg_nrst);
    exp_rst_cnt++;
    take_bits(3, gap);
    repeat (gap) @(posedge clk);
    drive_lock(1'b1, 1'b1);
    check_release_delay();
    read_event();
    read_event();
    read_word(REG_RSTCNT, exp_rst_cnt);
    end_test();
  endtask

  task automatic soft_and_dmi_reset();
    start_test("soft_and_dmi_reset");
    request_sw_reset();
    check_low_pulse();
    exp_rst_cnt++;
    pulse_dmi();
    check_low_pulse();
    exp_rst_cnt++;
    read_event();
    read_event();
    read_word(REG_RSTCNT, exp_rst_cnt);
    end_test();
  endtask

  task automatic overflow_drop();
    int   gap;
    logic err;
    start_test("overflow_drop");
    // Two more events than the FIFO holds, ending locked
    for (int i = 0; i < EV_DEPTH + 2; i++) begin
      take_bits(3, gap);
      repeat (gap + 1) @(posedge clk);
      drive_lock(1'b0, logic'(i[0]));
    end
    wait_sys_nrst(1'b1);
    read_word(REG_STATUS, status_bits(1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
    repeat (EV_DEPTH) read_event();
    read_word(REG_EVENT, 32'h0);
    exp_q.delete();
    apb_write(REG_CONTROL, 32'd1 << CT_CLR_OVF, err);
    cmp_bit(1'b0, err);
    read_word(REG_STATUS, status_bits(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic address_error();
    logic [11:0] bad_addr [2];
    logic [11:0] good_addr [4];
    logic [31:0] data;
    logic        err;
    start_test("address_error");
    bad_addr  = '{12'h010, 12'hFFC};
    good_addr = '{REG_STATUS, REG_EVENT, REG_CONTROL, REG_RSTCNT};
    foreach (bad_addr[i]) begin
      apb_read(bad_addr[i], data, err);
      cmp_bit(1'b1, err);
      apb_write(bad_addr[i], 32'h0, err);
      cmp_bit(1'b1, err);
    end
    foreach (good_addr[i]) begin
      apb_read(good_addr[i], data, err);
      cmp_bit(1'b0, err);
      apb_write(good_addr[i], 32'h0, err);
      cmp_bit(1'b0, err);
    end
    end_test();
  endtask

  initial begin
    arst_n       = 1'b0;
    dmireset     = 1'b0;
    sys_locked   = 1'b0;
    ddr_locked   = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    lfsr         = 16'd5;
    exp_rst_cnt  = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    bring_up();
    lock_loss();
    soft_and_dmi_reset();
    overflow_drop();
    address_error();
    $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- hw/prci_apb_regs.sv
`timescale 1ns/100ps

module prci_apb_regs (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [11:0] i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  input  logic        i_sys_lock_s,
  input  logic        i_ddr_lock_s,
  input  logic        i_sys_nrst,
  input  logic        i_sys_rst_start,
  output logic        o_sw_reset_req,
  prci_evq_if.reader_side q
);

  import prci_pkg::*;

  logic        access;
  logic        rd_access;
  logic        wr_access;
  logic        addr_ok;
  logic        clr_ovf_q;
  logic [31:0] status_word;
  logic [31:0] event_word;
  logic [31:0] rst_cnt;

  // Access phase of a transfer
  assign access    = i_psel && i_penable;
  assign rd_access = access && !i_pwrite;
  assign wr_access = access && i_pwrite;
  assign addr_ok   = (i_paddr == REG_STATUS) || (i_paddr == REG_EVENT) ||
                     (i_paddr == REG_CONTROL) || (i_paddr == REG_RSTCNT);

  // Zero wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = access && !addr_ok;

  always_comb begin
    status_word              = '0;
    status_word[ST_SYS_LOCK] = i_sys_lock_s;
    status_word[ST_DDR_LOCK] = i_ddr_lock_s;
    status_word[ST_SYS_NRST] = i_sys_nrst;
    status_word[ST_EV_AVAIL] = !q.empty;
    status_word[ST_OVERFLOW] = q.overflow;
  end

  // All zeros when nothing is logged
  always_comb begin
    event_word = '0;
    if (!q.empty) begin
      event_word[EVR_VALID]                                = 1'b1;
      event_word[EVR_CODE_LO +: $bits(prci_ev_code_e)]     = q.item.code;
      event_word[PRCI_STAMP_W-1:0]                         = q.item.stamp;
    end
  end

  always_comb begin
    o_prdata = '0;
    if (rd_access) begin
      case (i_paddr)
        REG_STATUS: o_prdata = status_word;
        REG_EVENT:  o_prdata = event_word;
        REG_RSTCNT: o_prdata = rst_cnt;
        default:    o_prdata = '0;
      endcase
    end
  end

  // Head leaves the queue in the same access phase that returns it
  assign q.pop = rd_access && (i_paddr == REG_EVENT) && !q.empty;

  assign q.clr_ovf = clr_ovf_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sw_reset_req <= 1'b0;
      clr_ovf_q      <= 1'b0;
    end else begin
      o_sw_reset_req <= wr_access && (i_paddr == REG_CONTROL) && i_pwdata[CT_SW_RESET];
      clr_ovf_q      <= wr_access && (i_paddr == REG_CONTROL) && i_pwdata[CT_CLR_OVF];
    end
  end

  // Saturating count of system reset assertions
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rst_cnt <= '0;
    end else if (i_sys_rst_start && (rst_cnt != '1)) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

endmodule

//--- hw/prci_event_fifo.sv
`timescale 1ns/100ps

module prci_event_fifo #(
  parameter type T_ITEM   = logic,
  parameter int  EV_DEPTH = 8
) (
  input  logic  i_clk,
  input  logic  i_arst_n,
  input  logic  i_push,
  input  T_ITEM i_item,
  prci_evq_if.fifo_side q
);

  localparam int AW = $clog2(EV_DEPTH);

  T_ITEM       mem [EV_DEPTH];
  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_push;
  logic        do_pop;
  logic        ovf_q;

  assign q.empty  = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // A push into a full buffer is lost
  assign do_push  = i_push && !full;
  assign do_pop   = q.pop && !q.empty;

  assign q.item     = mem[rd_ptr[AW-1:0]];
  assign q.overflow = ovf_q;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= i_item;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Sticky drop flag, a new drop wins over a clear
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ovf_q <= 1'b0;
    end else if (i_push && full) begin
      ovf_q <= 1'b1;
    end else if (q.clr_ovf) begin
      ovf_q <= 1'b0;
    end
  end

endmodule

//--- hw/prci_evq_if.sv
`timescale 1ns/100ps

// Read side of the event queue
interface prci_evq_if #(
  parameter type T_ITEM = logic
);

  // Strobes from the reader
  logic  pop;
  logic  clr_ovf;

  // Head entry, valid while empty is low
  T_ITEM item;
  logic  empty;
  // Sticky until clr_ovf
  logic  overflow;

  modport fifo_side (
    input  pop,
    input  clr_ovf,
    output item,
    output empty,
    output overflow
  );

  modport reader_side (
    output pop,
    output clr_ovf,
    input  item,
    input  empty,
    input  overflow
  );

endinterface

//--- hw/prci_pkg.sv
package prci_pkg;

  // Width of the free-running time stamp
  localparam int PRCI_STAMP_W = 16;

  // Kinds of logged events
  typedef enum logic [2:0] {
    EV_NONE       = 3'd0,
    EV_SYS_LOCK   = 3'd1,
    EV_SYS_UNLOCK = 3'd2,
    EV_DDR_LOCK   = 3'd3,
    EV_DDR_UNLOCK = 3'd4,
    EV_SW_RESET   = 3'd5,
    EV_DMI_RESET  = 3'd6
  } prci_ev_code_e;

  // One log entry, 19 bits
  typedef struct packed {
    prci_ev_code_e           code;
    logic [PRCI_STAMP_W-1:0] stamp;
  } prci_event_t;

  // APB register map, byte addresses
  localparam logic [11:0] REG_STATUS  = 12'h000;
  localparam logic [11:0] REG_EVENT   = 12'h004;
  localparam logic [11:0] REG_CONTROL = 12'h008;
  localparam logic [11:0] REG_RSTCNT  = 12'h00C;

  // STATUS bits
  localparam int ST_SYS_LOCK = 0;
  localparam int ST_DDR_LOCK = 1;
  localparam int ST_SYS_NRST = 2;
  localparam int ST_EV_AVAIL = 3;
  localparam int ST_OVERFLOW = 4;

  // CONTROL bits, write-only strobes
  localparam int CT_SW_RESET = 0;
  localparam int CT_CLR_OVF  = 1;

  // EVENT register layout
  localparam int EVR_VALID   = 31;
  localparam int EVR_CODE_LO = 16;

endpackage

//--- hw/prci_reset_seq.sv
`timescale 1ns/100ps

module prci_reset_seq #(
  parameter int RST_HOLD = 16
) (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_sys_locked,
  input  logic                  i_ddr_locked,
  input  logic                  i_dmireset,
  input  logic                  i_sw_reset_req,
  output logic                  o_sys_nrst,
  output logic                  o_dbg_nrst,
  output logic                  o_sys_lock_s,
  output logic                  o_ddr_lock_s,
  output logic                  o_sys_rst_start,
  output logic                  o_ev_push,
  output prci_pkg::prci_event_t o_ev
);

  import prci_pkg::*;

  localparam int HOLD_W = $clog2(RST_HOLD + 1);

  logic                    sys_meta;
  logic                    sys_s;
  logic                    sys_q;
  logic                    ddr_meta;
  logic                    ddr_s;
  logic                    ddr_q;
  logic                    dbg_meta;
  logic                    cause;
  logic [HOLD_W-1:0]       hold_cnt;
  logic [PRCI_STAMP_W-1:0] stamp_cnt;
  prci_ev_code_e           ev_code;

  // Two-flop synchronizers plus one stage of history for edge detection
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sys_meta <= 1'b0;
      sys_s    <= 1'b0;
      sys_q    <= 1'b0;
      ddr_meta <= 1'b0;
      ddr_s    <= 1'b0;
      ddr_q    <= 1'b0;
    end else begin
      sys_meta <= i_sys_locked;
      sys_s    <= sys_meta;
      sys_q    <= sys_s;
      ddr_meta <= i_ddr_locked;
      ddr_s    <= ddr_meta;
      ddr_q    <= ddr_s;
    end
  end

  assign o_sys_lock_s = sys_s;
  assign o_ddr_lock_s = ddr_s;

  // Debug reset only follows the power-on reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dbg_meta   <= 1'b0;
      o_dbg_nrst <= 1'b0;
    end else begin
      dbg_meta   <= 1'b1;
      o_dbg_nrst <= dbg_meta;
    end
  end

  assign cause = !sys_s || !ddr_s || i_sw_reset_req || i_dmireset;

  // Hold counter reloads while any cause is present
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hold_cnt        <= HOLD_W'(RST_HOLD);
      o_sys_nrst      <= 1'b0;
      o_sys_rst_start <= 1'b0;
    end else begin
      o_sys_rst_start <= cause && o_sys_nrst;
      if (cause) begin
        hold_cnt   <= HOLD_W'(RST_HOLD);
        o_sys_nrst <= 1'b0;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else begin
        o_sys_nrst <= 1'b1;
      end
    end
  end

  // Only the highest priority event of a cycle gets logged
  always_comb begin
    ev_code = EV_NONE;
    if (sys_s != sys_q) begin
      ev_code = sys_s ? EV_SYS_LOCK : EV_SYS_UNLOCK;
    end else if (ddr_s != ddr_q) begin
      ev_code = ddr_s ? EV_DDR_LOCK : EV_DDR_UNLOCK;
    end else if (i_dmireset) begin
      ev_code = EV_DMI_RESET;
    end else if (i_sw_reset_req) begin
      ev_code = EV_SW_RESET;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stamp_cnt <= '0;
      o_ev_push <= 1'b0;
    end else begin
      stamp_cnt <= stamp_cnt + 1'b1;
      o_ev_push <= (ev_code != EV_NONE);
    end
  end

  always_ff @(posedge i_clk) begin
    if (ev_code != EV_NONE) begin
      o_ev.code  <= ev_code;
      o_ev.stamp <= stamp_cnt;
    end
  end

endmodule

//--- hw/prci_top.sv
`timescale 1ns/100ps

module prci_top #(
  parameter int RST_HOLD = 16,
  parameter int EV_DEPTH = 8
) (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_dmireset,
  input  logic        i_sys_locked,
  input  logic        i_ddr_locked,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [11:0] i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  output logic        o_sys_nrst,
  output logic        o_dbg_nrst
);

  import prci_pkg::*;

  logic        sys_lock_s;
  logic        ddr_lock_s;
  logic        sys_rst_start;
  logic        sw_reset_req;
  logic        ev_push;
  prci_event_t ev;

  // Event queue between FIFO and register block
  prci_evq_if #(.T_ITEM(prci_event_t)) evq ();

  prci_reset_seq #(
    .RST_HOLD(RST_HOLD)
  ) reset_seq_inst (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_sys_locked   (i_sys_locked),
    .i_ddr_locked   (i_ddr_locked),
    .i_dmireset     (i_dmireset),
    .i_sw_reset_req (sw_reset_req),
    .o_sys_nrst     (o_sys_nrst),
    .o_dbg_nrst     (o_dbg_nrst),
    .o_sys_lock_s   (sys_lock_s),
    .o_ddr_lock_s   (ddr_lock_s),
    .o_sys_rst_start(sys_rst_start),
    .o_ev_push      (ev_push),
    .o_ev           (ev)
  );

  prci_event_fifo #(
    .T_ITEM  (prci_event_t),
    .EV_DEPTH(EV_DEPTH)
  ) event_fifo_inst (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_push  (ev_push),
    .i_item  (ev),
    .q       (evq.fifo_side)
  );

  prci_apb_regs apb_regs_inst (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_prdata       (o_prdata),
    .o_pready       (o_pready),
    .o_pslverr      (o_pslverr),
    .i_sys_lock_s   (sys_lock_s),
    .i_ddr_lock_s   (ddr_lock_s),
    .i_sys_nrst     (o_sys_nrst),
    .i_sys_rst_start(sys_rst_start),
    .o_sw_reset_req (sw_reset_req),
    .q              (evq.reader_side)
  );

endmodule

//--- list.f
hw/prci_pkg.sv
hw/prci_evq_if.sv
hw/prci_reset_seq.sv
hw/prci_event_fifo.sv
hw/prci_apb_regs.sv
hw/prci_top.sv
bench/prci_chk.sv
bench/prci_tb.sv
